// File: src.f
+incdir+sim
verilog/hw_manager_pkg.sv
verilog/hw_manager_if.sv
verilog/cfg_check.sv
verilog/fault_monitor.sv
verilog/power_sequencer.sv
verilog/shim_hw_manager.sv
sim/tb_shim_hw_manager.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator and run, the exit status gives pass or fail
cd "$(dirname "$0")" &&
  verilator --binary --assert --top-module tb_shim_hw_manager -f src.f &&
  ./obj_dir/Vtb_shim_hw_manager || exit 1

// File: sim/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH
`default_nettype none

// Lowest set bit of a flag or board vector, 0 when clear
function automatic int first_set(input logic [N_BOARDS-1:0] v);
  int idx;
  idx = -1;
  for (int i = 0; i < N_BOARDS; i++) begin
    if (v[i] && idx < 0) idx = i;
  end
  return (idx < 0) ? 0 : idx;
endfunction

// Config violation code, base plus lowest flag index
function automatic logic [CODE_W-1:0] cfg_code(input logic [N_CFG_FLAGS-1:0] cfg);
  return STS_CFG_OOB_BASE + CODE_W'(first_set(cfg));
endfunction

// Run-time priority, sys_en loss first and overflow last
task automatic predict_fault(input logic [PAT_W-1:0] p, output logic [CODE_W-1:0] code,
                             output logic [BOARD_W-1:0] board);
  logic [N_BOARDS-1:0] sense;
  logic [N_BOARDS-1:0] over;
  logic [N_BOARDS-1:0] under;
  logic [N_BOARDS-1:0] ovf;
  sense = p[3*N_BOARDS +: N_BOARDS];
  over  = p[2*N_BOARDS +: N_BOARDS];
  under = p[N_BOARDS +: N_BOARDS];
  ovf   = p[0 +: N_BOARDS];
  board = '0; // Scalar faults report board 0
  code  = STS_OK;
  if (!p[PAT_W-1]) code = STS_PS_SHUTDOWN;
  else if (p[PAT_W-2]) code = STS_LOCK_VIOL;
  else if (|sense) begin
    code  = STS_SHUTDOWN_SENSE;
    board = BOARD_W'(first_set(sense));
  end else if (p[PAT_W-3]) code = STS_EXT_SHUTDOWN;
  else if (|over) begin
    code  = STS_OVER_THRESH;
    board = BOARD_W'(first_set(over));
  end else if (|under) begin
    code  = STS_THRESH_UNDERFLOW;
    board = BOARD_W'(first_set(under));
  end else if (|ovf) begin
    code  = STS_THRESH_OVERFLOW;
    board = BOARD_W'(first_set(ovf));
  end
endtask

// Bit order {unlock_cfg, spi_clk_gate, spi_en, sense_en, block_bufs, force_n, rst_n, irq}
function automatic logic [7:0] safe_levels(input logic irq);
  return {7'b1000_101, irq};
endfunction

// Levels at each power-up step
function automatic logic [7:0] step_levels(input int step);
  case (step)
    0: return 8'b0000_1110;  // Force released
    1: return 8'b0110_1110;  // SPI enabled
    2: return 8'b0110_1100;  // Shutdown reset pulse
    3: return 8'b0111_0111;  // Run entry with interrupt
    default: return 8'b0111_0110;
  endcase
endfunction

function automatic logic [31:0] pack_status(input logic [BOARD_W-1:0] board,
                                            input logic [CODE_W-1:0] code,
                                            input logic [STATE_W-1:0] st);
  return {board, code, st};
endfunction

`default_nettype wire
`endif

// File: sim/tb_shim_hw_manager.sv
`timescale 1ns/1ps
`default_nettype none

module tb_shim_hw_manager;
  import hw_manager_pkg::*;

  localparam int N_CFG_RUNS = 6;
  localparam int N_FLT_RUNS = 16;
  localparam int N_RUNS     = N_CFG_RUNS + N_FLT_RUNS + 3; // Two timeouts and a last run
  localparam int WORST_RUN  = int'(SPI_RESET_MIN + SPI_RESET_WAIT + SHUTDOWN_FORCE_DELAY
                              + SPI_START_WAIT + SHUTDOWN_RESET_PULSE + SHUTDOWN_RESET_DELAY) + 20;
  localparam int TIMEOUT_CYCLES = N_RUNS * WORST_RUN + 100;
  localparam int PAT_W = 4 * N_BOARDS + 3; // {sys_en, lock, ext, sense, over, under, ovf}
  localparam logic [PAT_W-1:0] RUN_QUIET = {1'b1, {(PAT_W-1){1'b0}}}; // Enabled, no faults

  localparam int SPI_NORMAL     = 0;
  localparam int SPI_STUCK_LOW  = 1;
  localparam int SPI_STUCK_HIGH = 2;

  logic                   clk = 1'b0;
  logic                   aresetn;
  logic                   sys_en;
  logic                   spi_off = 1'b1; // Driven by the SPI model
  logic                   ext_shutdown;
  logic                   lock_viol;
  logic [N_CFG_FLAGS-1:0] cfg_oob;
  logic [N_BOARDS-1:0]    shutdown_sense;
  logic [N_BOARDS-1:0]    over_thresh;
  logic [N_BOARDS-1:0]    thresh_underflow;
  logic [N_BOARDS-1:0]    thresh_overflow;
  logic                   unlock_cfg;
  logic                   spi_clk_gate;
  logic                   spi_en;
  logic                   shutdown_sense_en;
  logic                   block_bufs;
  logic                   n_shutdown_force;
  logic                   n_shutdown_rst;
  logic                   ps_interrupt;
  logic [31:0]            status_word;
  logic [7:0]             ctrl;                  // All controls, see safe_levels
  logic [31:0]            rng = 32'hf7cd_9a1e;   // xorshift state
  int                     spi_mode = SPI_NORMAL;
  logic [3:0]             spi_delay = '0;        // Cycles from spi_en to SPI up
  logic [3:0]             spi_cnt = '0;
  int                     cycles = 0;
  string                  test_name = "reset";

  assign ctrl = {unlock_cfg, spi_clk_gate, spi_en, shutdown_sense_en,
                 block_bufs, n_shutdown_force, n_shutdown_rst, ps_interrupt};

  shim_hw_manager UUT (
    .clk               (clk),
    .aresetn           (aresetn),
    .sys_en            (sys_en),
    .spi_off           (spi_off),
    .ext_shutdown      (ext_shutdown),
    .lock_viol         (lock_viol),
    .cfg_oob           (cfg_oob),
    .shutdown_sense    (shutdown_sense),
    .over_thresh       (over_thresh),
    .thresh_underflow  (thresh_underflow),
    .thresh_overflow   (thresh_overflow),
    .unlock_cfg        (unlock_cfg),
    .spi_clk_gate      (spi_clk_gate),
    .spi_en            (spi_en),
    .shutdown_sense_en (shutdown_sense_en),
    .block_bufs        (block_bufs),
    .n_shutdown_force  (n_shutdown_force),
    .n_shutdown_rst    (n_shutdown_rst),
    .ps_interrupt      (ps_interrupt),
    .status_word       (status_word)
  );

  always #2 clk = ~clk; // 4 ns period

  // SPI subsystem, off until enabled, up after spi_delay cycles
  always @(negedge clk) begin
    if (!aresetn) begin
      spi_off <= 1'b1;
      spi_cnt <= '0;
    end else if (spi_mode == SPI_STUCK_LOW) begin
      spi_off <= 1'b0;
    end else if (spi_mode == SPI_STUCK_HIGH) begin
      spi_off <= 1'b1; // Never comes up
    end else if (!spi_en) begin
      spi_off <= 1'b1;
      spi_cnt <= '0;
    end else if (spi_cnt >= spi_delay) begin
      spi_off <= 1'b0;
    end else begin
      spi_cnt <= spi_cnt + 4'd1;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout in test %s after %0d cycles, the DUT never reached the awaited state",
               test_name, cycles);
      $display("Test failed");
      $fatal(1);
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic draw(output logic [31:0] r);
    rng = xorshift32(rng);
    r   = rng;
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("MISMATCH %s %s expected %h actual %h", test_name, what, expected, actual);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic check_status(input logic [BOARD_W-1:0] board, input logic [CODE_W-1:0] code,
                              input logic [STATE_W-1:0] st);
    check_value("status_word", pack_status(board, code, st), status_word);
  endtask

  task automatic check_levels(input logic [7:0] expected);
    check_value("controls", 32'(expected), 32'(ctrl));
  endtask

  // Random sparse fault pattern, never empty
  task automatic draw_pattern(input logic allow_drop, output logic [PAT_W-1:0] p);
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    draw(r0);
    draw(r1);
    draw(r2);
    draw(r3);
    p = '0;
    p[3*N_BOARDS +: N_BOARDS] = r0[7:0] & r0[15:8] & r0[23:16]; // About one board in eight
    p[2*N_BOARDS +: N_BOARDS] = r1[7:0] & r1[15:8] & r1[23:16];
    p[N_BOARDS +: N_BOARDS]   = r2[7:0] & r2[15:8] & r2[23:16];
    p[0 +: N_BOARDS]          = r3[7:0] & r3[15:8] & r3[23:16];
    p[PAT_W-1] = !allow_drop || (r0[26:24] != 3'd0); // sys_en
    p[PAT_W-2] = (r1[26:24] == 3'd0);                // lock_viol
    p[PAT_W-3] = (r2[26:24] == 3'd0);                // ext_shutdown
    if (p == RUN_QUIET) p[r3[26:24]] = 1'b1;         // Force one overflow
  endtask

  task automatic apply_faults(input logic [PAT_W-1:0] p);
    sys_en           = p[PAT_W-1];
    lock_viol        = p[PAT_W-2];
    ext_shutdown     = p[PAT_W-3];
    shutdown_sense   = p[3*N_BOARDS +: N_BOARDS];
    over_thresh      = p[2*N_BOARDS +: N_BOARDS];
    thresh_underflow = p[N_BOARDS +: N_BOARDS];
    thresh_overflow  = p[0 +: N_BOARDS];
  endtask

  // Waits for a state, counting interrupt cycles on the way
  task automatic wait_for_state(input logic [STATE_W-1:0] st, output int irqs);
    irqs = 0;
    do begin
      @(negedge clk);
      if (ps_interrupt) irqs++;
    end while (status_word[STATE_W-1:0] != st);
  endtask

  // Halt checks common to every halting path
  task automatic check_halted(input logic [BOARD_W-1:0] board, input logic [CODE_W-1:0] code);
    check_status(board, code, S_HALTED);
    check_levels(safe_levels(1'b1));
    @(negedge clk);
    check_status(board, code, S_HALTED);
    check_levels(safe_levels(1'b0)); // Interrupt lasts one cycle
  endtask

  task automatic cfg_fault_run();
    logic [31:0]            r;
    logic [N_CFG_FLAGS-1:0] cfg;
    int                     irqs;
    test_name = "cfg_fault";
    draw(r);
    cfg = (r[15:8] | 8'h01) << r[2:0]; // Lowest set index is r[2:0]
    apply_faults(RUN_QUIET);
    cfg_oob = cfg;
    wait_for_state(S_HALTED, irqs);
    check_value("interrupt pulses", 32'd1, 32'(irqs));
    check_halted('0, cfg_code(cfg));
  endtask

  task automatic power_up();
    logic [31:0] r;
    int          width;
    int          gap;
    test_name = "power_up";
    draw(r);
    spi_delay <= {1'b0, r[2:0]};
    cfg_oob = '0;
    apply_faults(RUN_QUIET);
    do begin
      @(negedge clk);
    end while (!n_shutdown_force);
    check_levels(step_levels(0));
    do begin
      @(negedge clk);
    end while (!spi_en);
    check_levels(step_levels(1));  // spi_en and spi_clk_gate together
    do begin
      @(negedge clk);
    end while (n_shutdown_rst);
    check_levels(step_levels(2));
    width = 0;
    while (!n_shutdown_rst) begin
      width++;
      @(negedge clk);
    end
    check_value("reset pulse width", SHUTDOWN_RESET_PULSE + 32'd1, 32'(width));
    gap = 0;
    while (block_bufs) begin
      gap++;
      @(negedge clk);
    end
    check_value("amp power wait", SHUTDOWN_RESET_DELAY + 32'd1, 32'(gap));
    check_levels(step_levels(3));
    check_status('0, STS_OK, S_RUNNING);
    @(negedge clk);
    check_levels(step_levels(4));
  endtask

  // Called one cycle after run entry, monitor armed
  task automatic runtime_fault_run();
    logic [31:0]        r;
    logic [PAT_W-1:0]   first;
    logic [PAT_W-1:0]   later;  // Arrives after capture, ignored
    logic [CODE_W-1:0]  exp_code;
    logic [BOARD_W-1:0] exp_board;
    int                 hold;
    test_name = "runtime_fault";
    draw(r);
    hold = 1 + int'(r[1:0]) % 3;
    repeat (int'(r[4:2])) @(negedge clk); // Quiet running cycles
    draw_pattern(1'b1, first);
    draw_pattern(1'b0, later);
    predict_fault(first, exp_code, exp_board);
    apply_faults(first);
    for (int k = 0; k < 3; k++) begin
      @(negedge clk);
      if (k == 0) check_value("state at capture", 32'(S_RUNNING), 32'(status_word[3:0]));
      if (k == 1) check_status(exp_board, exp_code, S_HALTING);
      if (k + 1 >= hold) apply_faults(later);
    end
    check_halted(exp_board, exp_code);
  endtask

  task automatic spi_timeout_run(input int mode, input logic [CODE_W-1:0] code,
                                 input string name);
    int irqs;
    test_name = name;
    spi_mode <= mode;
    @(negedge clk);
    cfg_oob = '0;
    apply_faults(RUN_QUIET);
    wait_for_state(S_HALTED, irqs);
    check_value("interrupt pulses", 32'd1, 32'(irqs));
    check_halted('0, code);
  endtask

  task automatic recover();
    test_name = "recovery";
    spi_mode <= SPI_NORMAL;
    cfg_oob = '0;
    apply_faults('0); // sys_en low acknowledges the halt
    @(negedge clk);
    check_status('0, STS_OK, S_IDLE);
    check_levels(safe_levels(1'b0));
  endtask

  initial begin
    aresetn = 1'b0;
    cfg_oob = '0;
    apply_faults('0);
    repeat (16) @(negedge clk);
    aresetn = 1'b1;
    @(negedge clk);
    check_status('0, STS_OK, S_IDLE);
    check_levels(safe_levels(1'b0));
    for (int i = 0; i < N_CFG_RUNS; i++) begin
      cfg_fault_run();
      recover();
    end
    for (int i = 0; i < N_FLT_RUNS; i++) begin
      power_up();  // Follows a recovery from the second pass on
      runtime_fault_run();
      recover();
    end
    spi_timeout_run(SPI_STUCK_LOW, STS_SPI_RESET_TIMEOUT, "spi_reset_timeout");
    recover();
    spi_timeout_run(SPI_STUCK_HIGH, STS_SPI_START_TIMEOUT, "spi_start_timeout");
    recover();
    power_up();
    $display("Test completed successfully");
    $finish;
  end

  `include "tb_model.svh"

endmodule

`default_nettype wire

// File: verilog/shim_hw_manager.sv
`timescale 1ns/1ps
`default_nettype none

module shim_hw_manager (
  input  logic                                   clk,
  input  logic                                   aresetn,
  input  logic                                   sys_en,
  input  logic                                   spi_off,
  input  logic                                   ext_shutdown,
  input  logic                                   lock_viol,
  input  logic [hw_manager_pkg::N_CFG_FLAGS-1:0] cfg_oob,          // Pre-start flags
  input  logic [hw_manager_pkg::N_BOARDS-1:0]    shutdown_sense,
  input  logic [hw_manager_pkg::N_BOARDS-1:0]    over_thresh,
  input  logic [hw_manager_pkg::N_BOARDS-1:0]    thresh_underflow,
  input  logic [hw_manager_pkg::N_BOARDS-1:0]    thresh_overflow,
  output logic                                   unlock_cfg,
  output logic                                   spi_clk_gate,
  output logic                                   spi_en,
  output logic                                   shutdown_sense_en,
  output logic                                   block_bufs,
  output logic                                   n_shutdown_force,
  output logic                                   n_shutdown_rst,
  output logic                                   ps_interrupt,
  output logic [31:0]                            status_word
);

  cfg_check_if chk_bus ();  // Sequencer to config checker
  fault_if     flt_bus ();  // Sequencer to run-time monitor

  cfg_check u_cfg_check (
    .clk     (clk),
    .aresetn (aresetn),
    .cfg_oob (cfg_oob),
    .chk     (chk_bus.check)
  );

  fault_monitor u_fault_monitor (
    .clk              (clk),
    .aresetn          (aresetn),
    .sys_en           (sys_en),
    .lock_viol        (lock_viol),
    .ext_shutdown     (ext_shutdown),
    .shutdown_sense   (shutdown_sense),
    .over_thresh      (over_thresh),
    .thresh_underflow (thresh_underflow),
    .thresh_overflow  (thresh_overflow),
    .mon              (flt_bus.monitor)
  );

  power_sequencer u_power_sequencer (
    .clk               (clk),
    .aresetn           (aresetn),
    .sys_en            (sys_en),
    .spi_off           (spi_off),
    .chk               (chk_bus.sequencer),
    .mon               (flt_bus.sequencer),
    .unlock_cfg        (unlock_cfg),
    .spi_clk_gate      (spi_clk_gate),
    .spi_en            (spi_en),
    .shutdown_sense_en (shutdown_sense_en),
    .block_bufs        (block_bufs),
    .n_shutdown_force  (n_shutdown_force),
    .n_shutdown_rst    (n_shutdown_rst),
    .ps_interrupt      (ps_interrupt),
    .status_word       (status_word)
  );

endmodule

`default_nettype wire

// File: verilog/power_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module power_sequencer (
  input  logic          clk,
  input  logic          aresetn,
  input  logic          sys_en,  // System enable
  input  logic          spi_off, // SPI subsystem reports off
  cfg_check_if.sequencer chk,
  fault_if.sequencer     mon,
  output logic          unlock_cfg,
  output logic          spi_clk_gate,
  output logic          spi_en,
  output logic          shutdown_sense_en,
  output logic          block_bufs,
  output logic          n_shutdown_force,
  output logic          n_shutdown_rst,
  output logic          ps_interrupt,
  output logic [31:0]   status_word // {board, code, state}
);
  import hw_manager_pkg::*;

  logic [STATE_W-1:0] state;
  logic [TIMER_W-1:0] timer;       // Shared timeout counter
  logic [BOARD_W-1:0] board_num;
  logic [CODE_W-1:0]  status_code;

  assign status_word = {board_num, status_code, state};

  // Armed once the run interrupt has been served
  assign mon.arm = (state == S_RUNNING) && !ps_interrupt;

  always_ff @(posedge clk) begin
    if (!aresetn) begin
      state             <= S_IDLE;
      timer             <= '0;
      chk.start         <= 1'b0;
      n_shutdown_force  <= 1'b0;
      n_shutdown_rst    <= 1'b1;
      shutdown_sense_en <= 1'b0;
      unlock_cfg        <= 1'b1;
      spi_clk_gate      <= 1'b0;
      spi_en            <= 1'b0;
      block_bufs        <= 1'b1;
      ps_interrupt      <= 1'b0;
      status_code       <= STS_OK;
      board_num         <= '0;
    end else begin
      chk.start <= 1'b0; // Single-cycle pulse
      case (state)
        S_IDLE: begin
          if (sys_en) begin
            state     <= S_CFG_CHECK;
            chk.start <= 1'b1;
          end
        end

        // Checker answers one cycle after start
        S_CFG_CHECK: begin
          if (chk.done) begin
            if (chk.fault) begin
              state       <= S_HALTING;
              status_code <= chk.code;
            end else begin
              state      <= S_CONFIRM_SPI_RST;
              timer      <= '0;
              unlock_cfg <= 1'b0; // Lock config
            end
          end
        end

        // SPI must report off after a minimum wait
        S_CONFIRM_SPI_RST: begin
          if (timer >= SPI_RESET_MIN && spi_off) begin
            state            <= S_POWER_ON_CTRL_BRD;
            timer            <= '0;
            n_shutdown_force <= 1'b1; // Release force
          end else if (timer >= SPI_RESET_WAIT) begin
            state       <= S_HALTING;
            status_code <= STS_SPI_RESET_TIMEOUT;
          end else begin
            timer <= timer + 1'b1;
          end
        end

        // Control board settles before SPI start
        S_POWER_ON_CTRL_BRD: begin
          if (timer >= SHUTDOWN_FORCE_DELAY) begin
            state        <= S_CONFIRM_SPI_START;
            timer        <= '0;
            spi_en       <= 1'b1;
            spi_clk_gate <= 1'b1;
          end else begin
            timer <= timer + 1'b1;
          end
        end

        S_CONFIRM_SPI_START: begin
          if (!spi_off) begin // SPI came up
            state          <= S_POWER_ON_AMP_BRD;
            timer          <= '0;
            n_shutdown_rst <= 1'b0; // Pulse start
          end else if (timer >= SPI_START_WAIT) begin
            state       <= S_HALTING;
            status_code <= STS_SPI_START_TIMEOUT;
          end else begin
            timer <= timer + 1'b1;
          end
        end

        // Shutdown reset pulse width
        S_POWER_ON_AMP_BRD: begin
          if (timer >= SHUTDOWN_RESET_PULSE) begin
            state          <= S_AMP_POWER_WAIT;
            timer          <= '0;
            n_shutdown_rst <= 1'b1;
          end else begin
            timer <= timer + 1'b1;
          end
        end

        S_AMP_POWER_WAIT: begin
          if (timer >= SHUTDOWN_RESET_DELAY) begin
            state             <= S_RUNNING;
            timer             <= '0;
            shutdown_sense_en <= 1'b1;
            block_bufs        <= 1'b0; // Open buffers
            ps_interrupt      <= 1'b1; // Run entered
          end else begin
            timer <= timer + 1'b1;
          end
        end

        // Monitor holds the first fault for us
        S_RUNNING: begin
          if (ps_interrupt) begin
            ps_interrupt <= 1'b0;
          end else if (mon.fault) begin
            state       <= S_HALTING;
            status_code <= mon.code;
            board_num   <= mon.board;
          end
        end

        // Back to safe levels, flag the halt
        S_HALTING: begin
          state             <= S_HALTED;
          timer             <= '0;
          n_shutdown_force  <= 1'b0;
          n_shutdown_rst    <= 1'b1;
          shutdown_sense_en <= 1'b0;
          unlock_cfg        <= 1'b1;
          spi_clk_gate      <= 1'b0;
          spi_en            <= 1'b0;
          block_bufs        <= 1'b1;
          ps_interrupt      <= 1'b1;
        end

        S_HALTED: begin
          ps_interrupt <= 1'b0;
          if (!sys_en) begin // Acknowledge by dropping enable
            state       <= S_IDLE;
            status_code <= STS_OK;
            board_num   <= '0;
          end
        end

        default: begin // Illegal state
          state             <= S_HALTED;
          timer             <= '0;
          n_shutdown_force  <= 1'b0;
          n_shutdown_rst    <= 1'b1;
          shutdown_sense_en <= 1'b0;
          unlock_cfg        <= 1'b1;
          spi_clk_gate      <= 1'b0;
          spi_en            <= 1'b0;
          block_bufs        <= 1'b1;
          ps_interrupt      <= 1'b1;
          status_code       <= STS_EMPTY;
          board_num         <= '0;
        end
      endcase
    end
  end

  // Reset pulse confined to its own state
  a_rst_pulse: assert property (@(posedge clk) disable iff (!aresetn)
    !n_shutdown_rst |-> (state == S_POWER_ON_AMP_BRD));

  // Buffers open only while running, or the halting cycle right after it
  a_bufs_open: assert property (@(posedge clk) disable iff (!aresetn)
    !block_bufs |-> (state == S_RUNNING ||
                     (state == S_HALTING && $past(state) == S_RUNNING)));

endmodule

`default_nettype wire

// File: verilog/fault_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module fault_monitor (
  input  logic                                clk,
  input  logic                                aresetn,
  input  logic                                sys_en,
  input  logic                                lock_viol,
  input  logic                                ext_shutdown,
  input  logic [hw_manager_pkg::N_BOARDS-1:0] shutdown_sense,   // Per board
  input  logic [hw_manager_pkg::N_BOARDS-1:0] over_thresh,      // Per board
  input  logic [hw_manager_pkg::N_BOARDS-1:0] thresh_underflow, // Per board
  input  logic [hw_manager_pkg::N_BOARDS-1:0] thresh_overflow,  // Per board
  fault_if.monitor                            mon
);
  import hw_manager_pkg::*;

  logic [N_FAULTS-1:0]  cond;           // Active conditions by index
  logic [N_BOARDS-1:0]  vec [N_FAULTS]; // Board vector per condition
  logic [FLT_IDX_W-1:0] sel;            // Winning condition

  // Scalar faults carry an empty board vector, so board reads 0
  always_comb begin
    vec[FLT_PS_SHUTDOWN]      = '0;
    vec[FLT_LOCK_VIOL]        = '0;
    vec[FLT_SHUTDOWN_SENSE]   = shutdown_sense;
    vec[FLT_EXT_SHUTDOWN]     = '0;
    vec[FLT_OVER_THRESH]      = over_thresh;
    vec[FLT_THRESH_UNDERFLOW] = thresh_underflow;
    vec[FLT_THRESH_OVERFLOW]  = thresh_overflow;
  end

  always_comb begin
    cond[FLT_PS_SHUTDOWN]      = !sys_en; // Loss of enable
    cond[FLT_LOCK_VIOL]        = lock_viol;
    cond[FLT_SHUTDOWN_SENSE]   = |shutdown_sense;
    cond[FLT_EXT_SHUTDOWN]     = ext_shutdown;
    cond[FLT_OVER_THRESH]      = |over_thresh;
    cond[FLT_THRESH_UNDERFLOW] = |thresh_underflow;
    cond[FLT_THRESH_OVERFLOW]  = |thresh_overflow;
  end

  // Priority pick, lowest index wins
  always_comb begin
    sel = '0;
    for (int i = N_FAULTS - 1; i >= 0; i--) begin
      if (cond[i]) sel = FLT_IDX_W'(i);
    end
  end

  // First fault while armed is held, later ones ignored
  always_ff @(posedge clk) begin
    if (!aresetn) begin
      mon.fault <= 1'b0;
      mon.code  <= STS_EMPTY;
      mon.board <= '0;
    end else if (!mon.arm) begin // Disarm clears capture
      mon.fault <= 1'b0;
      mon.code  <= STS_EMPTY;
      mon.board <= '0;
    end else if (!mon.fault && |cond) begin
      mon.fault <= 1'b1;
      mon.code  <= FLT_CODE[sel];
      mon.board <= lowest_set(vec[sel]);
    end
  end

  // Capture only follows an armed cycle
  a_rise_armed: assert property (@(posedge clk) disable iff (!aresetn)
    $rose(mon.fault) |-> $past(mon.arm));

  // Held fault keeps its code and board
  a_hold_stable: assert property (@(posedge clk) disable iff (!aresetn)
    (mon.fault && $past(mon.fault)) |-> ($stable(mon.code) && $stable(mon.board)));

endmodule

`default_nettype wire

// File: verilog/cfg_check.sv
`timescale 1ns/1ps
`default_nettype none

module cfg_check (
  input  logic                                   clk,
  input  logic                                   aresetn,
  input  logic [hw_manager_pkg::N_CFG_FLAGS-1:0] cfg_oob, // Out-of-bounds flags
  cfg_check_if.check                             chk
);
  import hw_manager_pkg::*;

  logic                   any_oob; // At least one flag set
  logic [BOARD_W-1:0]     oob_idx; // Lowest set flag
  logic [CODE_W-1:0]      oob_code;

  assign any_oob  = |cfg_oob;
  assign oob_idx  = lowest_set(cfg_oob); // Flag vector is board-wide
  assign oob_code = STS_CFG_OOB_BASE + CODE_W'(oob_idx);

  // Snapshot taken on start, result presented with done
  always_ff @(posedge clk) begin
    if (!aresetn) begin
      chk.done  <= 1'b0;
      chk.fault <= 1'b0;
      chk.code  <= STS_EMPTY;
    end else begin
      chk.done <= chk.start; // One-cycle pulse
      if (chk.start) begin
        chk.fault <= any_oob;
        chk.code  <= any_oob ? oob_code : STS_OK; // OK when clean
      end
    end
  end

  // Start is a lone pulse, answered by done exactly one cycle later
  a_start_done: assert property (@(posedge clk) disable iff (!aresetn)
    chk.start |=> (chk.done && !chk.start));

endmodule

`default_nettype wire

// File: verilog/hw_manager_if.sv
`timescale 1ns/1ps
`default_nettype none

// Config check handshake, start pulse then done pulse one cycle later
interface cfg_check_if;
  logic                              start;
  logic                              done;
  logic                              fault; // Any flag set
  logic [hw_manager_pkg::CODE_W-1:0] code;  // Valid with done

  modport sequencer (
    output start,
    input  done, fault, code
  );

  modport check (
    input  start,
    output done, fault, code
  );
endinterface

// Run-time fault capture, held until arm drops
interface fault_if;
  logic                               arm;
  logic                               fault;
  logic [hw_manager_pkg::CODE_W-1:0]  code;
  logic [hw_manager_pkg::BOARD_W-1:0] board;

  modport sequencer (
    output arm,
    input  fault, code, board
  );

  modport monitor (
    input  arm,
    output fault, code, board
  );
endinterface

`default_nettype wire

// File: verilog/hw_manager_pkg.sv
`default_nettype none

package hw_manager_pkg;

  // Widths
  localparam int N_BOARDS    = 8;  // Amplifier boards
  localparam int BOARD_W     = 3;  // Board number field
  localparam int STATE_W     = 4;  // State field
  localparam int CODE_W      = 25; // Status code field
  localparam int N_CFG_FLAGS = 8;  // Config out-of-bounds flags
  localparam int TIMER_W     = 32;

  // State encoding
  localparam logic [STATE_W-1:0] S_IDLE              = 4'd1;
  localparam logic [STATE_W-1:0] S_CONFIRM_SPI_RST   = 4'd2;
  localparam logic [STATE_W-1:0] S_POWER_ON_CTRL_BRD = 4'd3;
  localparam logic [STATE_W-1:0] S_CONFIRM_SPI_START = 4'd4;
  localparam logic [STATE_W-1:0] S_POWER_ON_AMP_BRD  = 4'd5;
  localparam logic [STATE_W-1:0] S_AMP_POWER_WAIT    = 4'd6;
  localparam logic [STATE_W-1:0] S_RUNNING           = 4'd7;
  localparam logic [STATE_W-1:0] S_HALTING           = 4'd8;
  localparam logic [STATE_W-1:0] S_HALTED            = 4'd9;
  localparam logic [STATE_W-1:0] S_CFG_CHECK         = 4'd10; // Waits on config checker

  // Status codes
  localparam logic [CODE_W-1:0] STS_EMPTY             = 25'h000;
  localparam logic [CODE_W-1:0] STS_OK                = 25'h001;
  localparam logic [CODE_W-1:0] STS_PS_SHUTDOWN       = 25'h002; // sys_en dropped
  localparam logic [CODE_W-1:0] STS_SPI_RESET_TIMEOUT = 25'h100;
  localparam logic [CODE_W-1:0] STS_SPI_START_TIMEOUT = 25'h101;
  localparam logic [CODE_W-1:0] STS_LOCK_VIOL         = 25'h200;
  localparam logic [CODE_W-1:0] STS_CFG_OOB_BASE      = 25'h201; // Plus flag index
  localparam logic [CODE_W-1:0] STS_SHUTDOWN_SENSE    = 25'h300;
  localparam logic [CODE_W-1:0] STS_EXT_SHUTDOWN      = 25'h301;
  localparam logic [CODE_W-1:0] STS_OVER_THRESH       = 25'h400;
  localparam logic [CODE_W-1:0] STS_THRESH_UNDERFLOW  = 25'h401;
  localparam logic [CODE_W-1:0] STS_THRESH_OVERFLOW   = 25'h402;

  // Delays in clock cycles, scaled down for simulation
  // Values for a 100 MHz clock noted per line
  localparam logic [TIMER_W-1:0] SPI_RESET_MIN        = 32'd10; // Same at 100 MHz
  localparam logic [TIMER_W-1:0] SPI_RESET_WAIT       = 32'd60; // 100_000_000, 1 s
  localparam logic [TIMER_W-1:0] SHUTDOWN_FORCE_DELAY = 32'd20; // 10_000_000, 100 ms
  localparam logic [TIMER_W-1:0] SPI_START_WAIT       = 32'd60; // 100_000_000, 1 s
  localparam logic [TIMER_W-1:0] SHUTDOWN_RESET_PULSE = 32'd8;  // 10_000, 100 us
  localparam logic [TIMER_W-1:0] SHUTDOWN_RESET_DELAY = 32'd20; // 10_000_000, 100 ms

  // Run-time fault index, lowest index wins
  localparam int N_FAULTS  = 7;
  localparam int FLT_IDX_W = 3;
  localparam int FLT_PS_SHUTDOWN     = 0;
  localparam int FLT_LOCK_VIOL       = 1;
  localparam int FLT_SHUTDOWN_SENSE  = 2;
  localparam int FLT_EXT_SHUTDOWN    = 3;
  localparam int FLT_OVER_THRESH     = 4;
  localparam int FLT_THRESH_UNDERFLOW = 5;
  localparam int FLT_THRESH_OVERFLOW = 6;

  // Status code per fault index
  localparam logic [CODE_W-1:0] FLT_CODE [N_FAULTS] = '{
    STS_PS_SHUTDOWN,
    STS_LOCK_VIOL,
    STS_SHUTDOWN_SENSE,
    STS_EXT_SHUTDOWN,
    STS_OVER_THRESH,
    STS_THRESH_UNDERFLOW,
    STS_THRESH_OVERFLOW
  };

  // Index of lowest set bit, 0 when none set
  function automatic logic [BOARD_W-1:0] lowest_set(input logic [N_BOARDS-1:0] v);
    logic [BOARD_W-1:0] idx;
    idx = '0;
    for (int i = N_BOARDS - 1; i >= 0; i--) begin
      if (v[i]) idx = BOARD_W'(i); // Lower bits overwrite higher
    end
    return idx;
  endfunction

endpackage

`default_nettype wire
